/* logic/data_memory.sv */
`default_nettype none
`timescale 1ns/10ps

`include "rv_defines.svh"

module data_memory (
    input  logic              i_clock,  // Clock
    input  rv_pkg::ram_port_t i_ram,    // Address, lanes and strobes
    output rv_pkg::data_t     o_rdata); // Word read, one cycle later

    rv_pkg::data_t mem [`RV_MEM_WORDS];  // Word array
    rv_pkg::data_t rdata_q;

    // ----------------------------------------
    // Write, enabled lanes only
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_ram.en && i_ram.we) begin
            for (int b = 0; b < 4; b++) begin
                if (i_ram.byte_en[b])
                    mem[i_ram.addr][b*8 +: 8] <= i_ram.wdata[b*8 +: 8];
            end
        end
    end

    // Registered read, returns the old word on a write
    always_ff @(posedge i_clock) begin
        if (i_ram.en)
            rdata_q <= mem[i_ram.addr];
    end

    assign o_rdata = rdata_q;

endmodule

`default_nettype wire

/* logic/mem_access_fsm.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_access_fsm (
    input  logic              i_clock,        // Clock
    input  logic              i_rst_n,        // Sync reset, active low

    // Request side
    input  logic              i_valid,
    output logic              o_ready,
    input  rv_pkg::mem_req_t  i_req,
    output rv_pkg::mem_req_t  o_req_q,        // Held request for the datapath

    // Datapath and timer control
    input  logic              i_align_error,  // From the aligner
    output logic              o_timer_start,
    input  logic              i_timer_done,
    output logic              o_ram_fire,     // One-cycle RAM strobe enable
    input  rv_pkg::data_t     i_wb_data,      // Selected write-back word

    // Response side
    output logic              o_valid,
    input  logic              i_ready,
    output rv_pkg::mem_resp_t o_resp);

    typedef enum logic [1:0] {
        S_IDLE,     // Ready for a request
        S_WAIT,     // Wait states
        S_ACCESS,   // RAM read word valid
        S_RESPOND   // Response held
    } state_e;

    state_e            state_q;
    state_e            state_d;
    logic              first_q;     // First cycle in S_WAIT
    rv_pkg::mem_req_t  req_q;
    rv_pkg::mem_resp_t resp_q;

    logic accept;     // Input transfer
    logic mem_op;     // Load or store
    logic direct;     // Finishes without the RAM
    logic load_resp;  // Capture the response

    assign accept = i_valid && o_ready;
    assign mem_op = req_q.wr_en || req_q.rd_en;
    assign direct = !mem_op || i_align_error;  // Misaligned ops never reach the RAM

    assign o_timer_start = (state_q == S_WAIT) && first_q && !direct;
    assign o_ram_fire    = (state_q == S_WAIT) && !first_q && i_timer_done;

    // Direct requests answer on their first cycle, memory ops after the read
    assign load_resp = ((state_q == S_WAIT) && first_q && direct) || (state_q == S_ACCESS);

    // ----------------------------------------
    // Next state
    // ----------------------------------------

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            S_IDLE:    if (accept) state_d = S_WAIT;
            S_WAIT: begin
                if (first_q && direct) state_d = S_RESPOND;
                else if (o_ram_fire)   state_d = S_ACCESS;
            end
            S_ACCESS:  state_d = S_RESPOND;  // Read word is on the RAM output
            S_RESPOND: if (i_ready) state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            first_q <= 1'b0;
        end else begin
            state_q <= state_d;
            first_q <= accept;
        end
    end

    // Payload registers
    always_ff @(posedge i_clock) begin
        if (accept)
            req_q <= i_req;
        if (load_resp) begin
            resp_q.wb_data     <= i_wb_data;
            resp_q.align_error <= i_align_error;
        end
    end

    assign o_ready = (state_q == S_IDLE);     // One item in flight
    assign o_valid = (state_q == S_RESPOND);
    assign o_resp  = resp_q;                  // Stable until the transfer
    assign o_req_q = req_q;

endmodule

`default_nettype wire

/* logic/mem_lane_align.sv */
`default_nettype none
`timescale 1ns/10ps

`include "rv_defines.svh"

module mem_lane_align (
    input  rv_pkg::mem_req_t  i_req,          // Held request
    input  logic              i_fire,         // Strobe enable from the FSM
    output rv_pkg::ram_port_t o_ram,
    output logic              o_align_error,
    input  rv_pkg::data_t     i_ram_rdata,    // Raw word from the RAM
    output rv_pkg::data_t     o_load_data);   // Extracted and extended

    logic [1:0]        lane;        // Low address bits
    logic              misaligned;
    logic              mem_op;
    rv_pkg::mem_word_u st_word;     // Store word, lane-replicated
    rv_pkg::mem_word_u ld_word;     // Read word
    logic [7:0]        ld_byte;
    logic [15:0]       ld_half;
    logic              ext;         // Sign bit to extend with

    assign lane   = i_req.result[1:0];
    assign mem_op = i_req.wr_en || i_req.rd_en;

    // ----------------------------------------
    // Alignment and store lanes
    // ----------------------------------------

    always_comb begin
        misaligned    = 1'b0;
        o_ram.byte_en = 4'b1111;
        st_word.word  = i_req.store_data;
        unique case (i_req.access)
            rv_pkg::ACCESS_BYTE: begin
                o_ram.byte_en = 4'b0001 << lane;
                st_word.bytes = {4{i_req.store_data[7:0]}};   // Same byte on every lane
            end
            rv_pkg::ACCESS_HALF: begin
                misaligned     = lane[0];
                o_ram.byte_en  = lane[1] ? 4'b1100 : 4'b0011;
                st_word.halves = {2{i_req.store_data[15:0]}};
            end
            default: begin
                misaligned = (lane != 2'b00);   // Word, also the unused code
            end
        endcase
    end

    assign o_align_error = mem_op && misaligned;

    assign o_ram.addr  = i_req.result[`RV_ADDR_W-1:2];
    assign o_ram.wdata = st_word.word;
    assign o_ram.en    = i_fire && mem_op && !misaligned;
    assign o_ram.we    = i_fire && i_req.wr_en && !misaligned;

    // ----------------------------------------
    // Load extraction
    // ----------------------------------------

    assign ld_word.word = i_ram_rdata;
    assign ld_byte      = ld_word.bytes[lane];
    assign ld_half      = ld_word.halves[lane[1]];

    always_comb begin
        unique case (i_req.access)
            rv_pkg::ACCESS_BYTE: begin
                ext         = !i_req.is_unsigned && ld_byte[7];
                o_load_data = {{24{ext}}, ld_byte};
            end
            rv_pkg::ACCESS_HALF: begin
                ext         = !i_req.is_unsigned && ld_half[15];
                o_load_data = {{16{ext}}, ld_half};
            end
            default: begin
                ext         = 1'b0;            // Nothing to extend
                o_load_data = ld_word.word;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------

`define RV_DATA_W    32    // Register and memory word width
`define RV_ADDR_W    12    // Byte address width, PC and data

// ----------------------------------------
// Data RAM
// ----------------------------------------

// Depth in words, must match the word address range
`define RV_MEM_WORDS 1024

// Wait states before the RAM is fired
// Must be at least 1
`define RV_MEM_WAIT  2

`endif

/* logic/rv_pkg.sv */
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

    typedef logic [`RV_DATA_W-1:0] data_t;       // One data word
    typedef logic [`RV_ADDR_W-1:0] inst_addr_t;  // Byte address, PC or data

    // Access size, same coding as funct3[1:0]
    typedef enum logic [1:0] {
        ACCESS_BYTE = 2'b00,
        ACCESS_HALF = 2'b01,
        ACCESS_WORD = 2'b10
    } mem_access_e;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU = 2'b00,  // ALU result
        WB_MEM = 2'b01,  // Load data
        WB_PC4 = 2'b10   // Return address
    } wb_sel_e;

    // ----------------------------------------
    // Stage ports
    // ----------------------------------------

    typedef struct packed {
        inst_addr_t  pc;           // Instruction address
        data_t       result;       // ALU result, also the data address
        data_t       store_data;   // Raw store operand
        logic        wr_en;        // Store
        logic        rd_en;        // Load
        mem_access_e access;       // Size of the access
        logic        is_unsigned;  // Zero-extend loads
        wb_sel_e     wb_sel;       // Write-back source
    } mem_req_t;

    typedef struct packed {
        data_t wb_data;      // Register write-back value
        logic  align_error;  // Misaligned access, memory untouched
    } mem_resp_t;

    // Aligner to RAM
    typedef struct packed {
        logic [`RV_ADDR_W-3:0] addr;     // Word address
        logic [3:0]            byte_en;  // One bit per lane
        data_t                 wdata;    // Lane-replicated store data
        logic                  we;       // Write strobe
        logic                  en;       // Access strobe
    } ram_port_t;

    // One memory word seen whole, as lanes of bytes or of halfwords
    typedef union packed {
        data_t            word;
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage

`default_nettype wire

/* logic/stage_mem.sv */
`default_nettype none
`timescale 1ns/10ps

`include "rv_defines.svh"

module stage_mem (
    input  logic              i_clock,  // Clock
    input  logic              i_rst_n,  // Sync reset, active low

    // From execute
    input  logic              i_valid,
    output logic              o_ready,  // Low while an access is in flight
    input  rv_pkg::mem_req_t  i_req,

    // To write-back
    output logic              o_valid,
    input  logic              i_ready,
    output rv_pkg::mem_resp_t o_resp);

    rv_pkg::mem_req_t  req_q;        // Held request
    rv_pkg::ram_port_t ram_port;
    rv_pkg::data_t     ram_rdata;
    rv_pkg::data_t     load_data;    // Extended load
    rv_pkg::data_t     wb_data;
    rv_pkg::inst_addr_t pc4;
    logic              align_error;
    logic              timer_start;
    logic              timer_done;
    logic              ram_fire;

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------

    mem_access_fsm
    fsm (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_valid       (i_valid),
        .o_ready       (o_ready),
        .i_req         (i_req),
        .o_req_q       (req_q),
        .i_align_error (align_error),
        .o_timer_start (timer_start),
        .i_timer_done  (timer_done),
        .o_ram_fire    (ram_fire),
        .i_wb_data     (wb_data),
        .o_valid       (o_valid),
        .i_ready       (i_ready),
        .o_resp        (o_resp));

    wait_state_timer
    timer (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_start (timer_start),
        .o_done  (timer_done));

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    mem_lane_align
    aligner (
        .i_req         (req_q),
        .i_fire        (ram_fire),
        .o_ram         (ram_port),
        .o_align_error (align_error),
        .i_ram_rdata   (ram_rdata),
        .o_load_data   (load_data));

    data_memory
    ram (
        .i_clock (i_clock),
        .i_ram   (ram_port),
        .o_rdata (ram_rdata));

    // Return address
    assign pc4 = req_q.pc + `RV_ADDR_W'(4);

    // Write-back source
    always_comb begin
        unique case (req_q.wb_sel)
            rv_pkg::WB_MEM: wb_data = load_data;
            rv_pkg::WB_PC4: wb_data = {{(`RV_DATA_W - `RV_ADDR_W){1'b0}}, pc4};  // Zero-extended
            default:        wb_data = req_q.result;  // ALU result
        endcase
    end

endmodule

`default_nettype wire

/* logic/wait_state_timer.sv */
`default_nettype none
`timescale 1ns/10ps

`include "rv_defines.svh"

module wait_state_timer (
    input  logic i_clock,  // Clock
    input  logic i_rst_n,  // Sync reset, active low
    input  logic i_start,  // Load the wait count
    output logic o_done);  // Pulse, RV_MEM_WAIT cycles after start

    localparam int unsigned CNT_W = $clog2(`RV_MEM_WAIT + 1);

    logic [CNT_W-1:0] cnt_q;   // Cycles left
    logic             busy_q;  // Counting

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            cnt_q  <= '0;
            busy_q <= 1'b0;
        end else if (i_start) begin
            cnt_q  <= CNT_W'(`RV_MEM_WAIT - 1);  // Start cycle counts as the first
            busy_q <= 1'b1;
        end else if (busy_q) begin
            if (cnt_q == '0) busy_q <= 1'b0;       // Done seen, stop
            else             cnt_q  <= cnt_q - 1'b1;
        end
    end

    assign o_done = busy_q && (cnt_q == '0);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_stage_mem -f sim.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation finished without failures"

/* sim.f */
+incdir+logic
logic/rv_pkg.sv
logic/wait_state_timer.sv
logic/mem_lane_align.sv
logic/data_memory.sv
logic/mem_access_fsm.sv
logic/stage_mem.sv
test/tb_stage_mem.sv

/* test/tb_stage_mem.sv */
`default_nettype none
`timescale 1ns/10ps

`include "rv_defines.svh"

module tb_stage_mem;

    localparam int TIMEOUT   = 50;                  // Edges per wait
    localparam int MEM_EDGES = `RV_MEM_WAIT + 2;    // Accept to o_valid, RAM access

    logic              i_clock = 1'b0;
    logic              i_rst_n;
    logic              i_valid;
    logic              o_ready;
    rv_pkg::mem_req_t  i_req;
    logic              o_valid;
    logic              i_ready;
    rv_pkg::mem_resp_t o_resp;

    integer            seed = 32'hc28f_5055;
    int                checks = 0;
    int                errors = 0;
    int                checks_at;    // Counts at test start
    int                errors_at;
    logic              timed_out = 1'b0;   // A wait ran out, later accesses are skipped
    logic [31:0]       shadow [1024];   // Expected RAM contents
    logic [9:0]        waddr [16];      // Words written in the round trip

    stage_mem i_stage_mem (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_req   (i_req),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_resp  (o_resp));

    always #50 i_clock = ~i_clock;   // 100 ns period

    // ----------------------------------------
    // Protocol assertions
    // ----------------------------------------

    function automatic void note_error(input string msg);
        errors++;
        $display("Assertion failed: %s", msg);
    endfunction

    a_reset: assert property (@(posedge i_clock) !i_rst_n |=> (!o_valid && o_ready
            && !i_stage_mem.timer_done && !i_stage_mem.ram_port.en && !i_stage_mem.ram_port.we))
        else note_error("DUT is not idle after reset");
    a_hold: assert property (@(posedge i_clock) disable iff (!i_rst_n)
            (o_valid && !i_ready) |=> (o_valid && $stable(o_resp)))
        else note_error("response dropped or changed while i_ready was low");
    a_busy: assert property (@(posedge i_clock) disable iff (!i_rst_n)
            o_valid |-> (!o_ready && !i_stage_mem.ram_port.en))
        else note_error("new request or RAM access while a response was held");

    // ----------------------------------------
    // Reference model and helpers
    // ----------------------------------------

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic give_up(input string what);
        $display("Timeout while waiting for %s", what);
        timed_out = 1'b1;
    endtask

    function automatic rv_pkg::mem_req_t make_req(input logic [11:0] pc,
            input logic [31:0] result, input logic [31:0] sdata, input logic wr, input logic rd,
            input rv_pkg::mem_access_e acc, input logic uns, input rv_pkg::wb_sel_e wb);
        rv_pkg::mem_req_t r;
        r.pc          = pc;
        r.result      = result;
        r.store_data  = sdata;
        r.wr_en       = wr;
        r.rd_en       = rd;
        r.access      = acc;
        r.is_unsigned = uns;
        r.wb_sel      = wb;
        return r;
    endfunction

    // Byte enable rule applied to the shadow copy
    task automatic shadow_store(input logic [11:0] addr, input rv_pkg::mem_access_e acc,
                                input logic [31:0] data);
        if (acc == rv_pkg::ACCESS_BYTE)
            shadow[addr[11:2]][addr[1:0]*8 +: 8] = data[7:0];
        else if (acc == rv_pkg::ACCESS_HALF)
            shadow[addr[11:2]][addr[1]*16 +: 16] = data[15:0];
        else
            shadow[addr[11:2]] = data;
    endtask

    function automatic logic [31:0] exp_load(input logic [11:0] addr,
                                             input rv_pkg::mem_access_e acc, input logic uns);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = shadow[addr[11:2]];
        b    = word[addr[1:0]*8 +: 8];              // Addressed byte lane
        h    = addr[1] ? word[31:16] : word[15:0];
        if (acc == rv_pkg::ACCESS_BYTE)
            return uns ? {24'h0, b} : {{24{b[7]}}, b};
        if (acc == rv_pkg::ACCESS_HALF)
            return uns ? {16'h0, h} : {{16{h[15]}}, h};
        return word;
    endfunction

    // One transfer in, one out; hold keeps i_ready low that many edges
    task automatic run_access(input rv_pkg::mem_req_t req, input int hold,
                              output rv_pkg::mem_resp_t resp, output int edges);
        int n;
        resp    = '0;
        edges   = 0;
        if (timed_out)
            return;
        i_valid <= 1'b1;
        i_req   <= req;
        n = 0;
        do begin
            @(posedge i_clock);
            n++;
        end while (!o_ready && n < TIMEOUT);
        if (!o_ready) begin
            give_up("o_ready");
        end else begin
            i_valid <= 1'b0;                  // Accepted on this edge
            i_ready <= (hold == 0);
            n = 0;
            do begin
                @(posedge i_clock);
                n++;
            end while (!o_valid && n < TIMEOUT);
            if (!o_valid) begin
                give_up("o_valid");
            end else begin
                resp  = o_resp;
                edges = n - 1;                // o_valid rose one edge before it is seen
                if (hold > 0) begin
                    repeat (hold) @(posedge i_clock);
                    i_ready <= 1'b1;
                    @(posedge i_clock);       // Transfer edge
                end
            end
        end
    endtask

    task automatic expect_access(input rv_pkg::mem_req_t req, input int hold,
            input logic [31:0] exp_data, input logic exp_err, input int exp_edges);
        rv_pkg::mem_resp_t resp;
        int                edges;
        run_access(req, hold, resp, edges);
        if (!timed_out) begin
            check_val("wb_data", resp.wb_data, exp_data);
            check_val("align_error", 32'(resp.align_error), 32'(exp_err));
            check_val("latency", edges, exp_edges);
        end
    endtask

    task automatic load_word(input logic [9:0] w);
        expect_access(make_req(12'h0, {20'h0, w, 2'b00}, 32'h0, 1'b0, 1'b1,
                      rv_pkg::ACCESS_WORD, 1'b0, rv_pkg::WB_MEM),
                      0, shadow[w], 1'b0, MEM_EDGES);
    endtask

    // Byte loads on all lanes, half loads on both halves, signed and unsigned
    task automatic extension_sweep(input logic [9:0] w);
        logic [11:0] addr;
        int          l;
        int          u;
        for (l = 0; l < 4; l++) begin
            for (u = 0; u < 2; u++) begin
                addr = {w, 2'(l)};
                expect_access(make_req(12'h0, {20'h0, addr}, 32'h0, 1'b0, 1'b1,
                              rv_pkg::ACCESS_BYTE, u[0], rv_pkg::WB_MEM), 0,
                              exp_load(addr, rv_pkg::ACCESS_BYTE, u[0]), 1'b0, MEM_EDGES);
                if (!l[0])
                    expect_access(make_req(12'h0, {20'h0, addr}, 32'h0, 1'b0, 1'b1,
                                  rv_pkg::ACCESS_HALF, u[0], rv_pkg::WB_MEM), 0,
                                  exp_load(addr, rv_pkg::ACCESS_HALF, u[0]), 1'b0, MEM_EDGES);
            end
        end
    endtask

    task automatic begin_test();
        checks_at = checks;
        errors_at = errors;
    endtask

    task automatic end_test(input string name);
        $display("%-24s %0d checks, %0d errors", name, checks - checks_at, errors - errors_at);
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin
        rv_pkg::mem_access_e acc;
        logic [31:0]         rnd;
        logic [31:0]         res;
        logic [11:0]         pc;
        logic [11:0]         addr;
        logic [9:0]          w;
        logic [1:0]          lane;
        int                  k;
        int                  hold;

        i_rst_n = 1'b0;
        i_valid = 1'b0;
        i_ready = 1'b1;
        i_req   = '0;
        repeat (10) @(posedge i_clock);
        i_rst_n <= 1'b1;

        begin_test();                         // ALU result and return address
        for (k = 0; k < 8; k++) begin
            pc  = 12'($unsigned($random(seed)));
            res = $random(seed);
            if (k[0])
                expect_access(make_req(pc, res, 32'h0, 1'b0, 1'b0, rv_pkg::ACCESS_WORD, 1'b0,
                              rv_pkg::WB_PC4), 0, {20'h0, pc + 12'd4}, 1'b0, 1);
            else
                expect_access(make_req(pc, res, 32'h0, 1'b0, 1'b0, rv_pkg::ACCESS_WORD, 1'b0,
                              rv_pkg::WB_ALU), 0, res, 1'b0, 1);
        end
        end_test("non-memory requests");

        begin_test();
        for (k = 0; k < 16; k++) begin
            waddr[k] = 10'($unsigned($random(seed)));
            rnd      = $random(seed);
            addr     = {waddr[k], 2'b00};
            expect_access(make_req(12'h0, {20'h0, addr}, rnd, 1'b1, 1'b0, rv_pkg::ACCESS_WORD,
                          1'b0, rv_pkg::WB_ALU), 0, {20'h0, addr}, 1'b0, MEM_EDGES);
            shadow_store(addr, rv_pkg::ACCESS_WORD, rnd);
        end
        for (k = 0; k < 16; k++)
            load_word(waddr[k]);
        end_test("word round trip");

        begin_test();
        for (k = 0; k < 12; k++) begin
            w   = waddr[$unsigned($random(seed)) % 16];
            rnd = $random(seed);
            if (rnd[0]) begin
                acc  = rv_pkg::ACCESS_BYTE;
                lane = rnd[2:1];
            end else begin
                acc  = rv_pkg::ACCESS_HALF;
                lane = {rnd[1], 1'b0};
            end
            addr = {w, lane};
            rnd  = $random(seed);
            expect_access(make_req(12'h0, {20'h0, addr}, rnd, 1'b1, 1'b0, acc, 1'b0,
                          rv_pkg::WB_ALU), 0, {20'h0, addr}, 1'b0, MEM_EDGES);
            shadow_store(addr, acc, rnd);
            load_word(w);                     // Other lanes must be untouched
        end
        end_test("partial stores");

        begin_test();
        addr = {waddr[0], 2'b00};
        rnd  = 32'h7f80_807f;                 // Top bits set and clear on bytes and halves
        expect_access(make_req(12'h0, {20'h0, addr}, rnd, 1'b1, 1'b0, rv_pkg::ACCESS_WORD,
                      1'b0, rv_pkg::WB_ALU), 0, {20'h0, addr}, 1'b0, MEM_EDGES);
        shadow_store(addr, rv_pkg::ACCESS_WORD, rnd);
        extension_sweep(waddr[0]);
        extension_sweep(waddr[1]);
        end_test("load extension");

        begin_test();
        for (k = 0; k < 6; k++) begin
            w = waddr[k];
            if (!k[0]) begin
                acc  = rv_pkg::ACCESS_HALF;
                lane = {k[1], 1'b1};
            end else begin
                acc  = rv_pkg::ACCESS_WORD;
                lane = 2'((k % 3) + 1);
            end
            addr = {w, lane};
            rnd  = $random(seed);
            expect_access(make_req(12'h0, {20'h0, addr}, rnd, k < 3, k >= 3, acc, 1'b0,
                          rv_pkg::WB_ALU), 0, {20'h0, addr}, 1'b1, 1);
            load_word(w);                     // Shadow unchanged
        end
        end_test("misalignment");

        begin_test();                         // Checking mostly in a_hold and a_busy
        for (k = 0; k < 10; k++) begin
            hold = 1 + $unsigned($random(seed)) % 6;
            w    = waddr[$unsigned($random(seed)) % 16];
            pc   = 12'($unsigned($random(seed)));
            if (k[0])
                expect_access(make_req(12'h0, {20'h0, w, 2'b00}, 32'h0, 1'b0, 1'b1,
                              rv_pkg::ACCESS_WORD, 1'b0, rv_pkg::WB_MEM),
                              hold, shadow[w], 1'b0, MEM_EDGES);
            else
                expect_access(make_req(pc, 32'h0, 32'h0, 1'b0, 1'b0, rv_pkg::ACCESS_WORD, 1'b0,
                              rv_pkg::WB_PC4), hold, {20'h0, pc + 12'd4}, 1'b0, 1);
        end
        end_test("back-pressure");

        $display("Total %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
